// ==== bench/cpu_bus_vectors.txt ====
// port we sel addr wdata interlock expected_rdata, all hex
// port 1 ibus, 2 dbus, 3 dbus started together with the ibus line below it
// writes expect the port's previous read data
2 0 f 00000010 00000000 0 5a5a0004
1 0 f 00000000 00000000 0 5a5a0000
1 0 f 00000004 00000000 0 5a5a0001
1 0 f 00000008 00000000 0 5a5a0002
2 0 f 00000100 00000000 0 5a5a0040
2 1 f 00000100 11223344 0 5a5a0040
2 0 f 00000100 00000000 0 11223344
2 1 1 00000104 aabbccdd 0 11223344
2 0 f 00000104 00000000 0 5a5a00dd
2 1 6 00000108 12345678 0 5a5a00dd
2 0 f 00000108 00000000 0 5a345642
2 1 8 0000010c 9f000000 0 5a345642
1 0 f 0000010c 00000000 0 9f5a0043
1 0 f 00000100 00000000 0 11223344
3 0 f 00000200 00000000 0 5a5a0080
1 0 f 00000300 00000000 0 5a5a00c0
3 1 f 00000400 cafef00d 0 5a5a0080
1 0 f 00000400 00000000 0 cafef00d
3 0 f 00000104 00000000 0 5a5a00dd
1 0 f 00000014 00000000 0 5a5a0005
2 0 f 00000020 00000000 1 5a5a0008
1 0 f 00000018 00000000 1 5a5a0006
2 1 3 00000024 0000beef 1 5a5a0008
2 0 f 00000024 00000000 0 5a5abeef
1 0 f 00000024 00000000 0 5a5abeef
2 0 f 00000ffc 00000000 0 5a5a03ff
1 0 f 00000800 00000000 0 5a5a0200
2 1 f 00000ffc 01020304 0 5a5a03ff
2 0 f 00000ffc 00000000 0 01020304
3 1 3 00000ffc 0000a5a5 0 01020304
1 0 f 00000ffc 00000000 0 0102a5a5
2 0 f 00000ffc 00000000 0 0102a5a5
1 0 f 00000ffc 00000000 1 0102a5a5
3 0 f 00000010 00000000 0 5a5a0004
1 0 f 00000010 00000000 0 5a5a0004
2 1 f 00000010 deadbeef 0 5a5a0004
1 0 f 00000010 00000000 0 deadbeef
2 0 f 00000010 00000000 0 deadbeef
1 0 f 00000000 00000000 0 5a5a0000
2 0 f 00000104 00000000 1 5a5a00dd

// ==== cpu_bus.f ====
hdl/cpu_bus_pkg.sv
hdl/cpu_bus_bridge.sv
hdl/cpu_bus_arbiter.sv
hdl/cpu_bus_top.sv
bench/cpu_bus_mem_model.sv
bench/cpu_bus_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the cpu bus testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=obj_dir/cpu_bus_sim

verilator --binary --timing -j 0 -f cpu_bus.f --top-module cpu_bus_tb -o cpu_bus_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
	echo "simulation reported failure"
	exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

// ==== bench/cpu_bus_tb.sv ====
// cpu bus testbench
// plays the core on both bus ports, memory model on the wishbone side

module cpu_bus_tb
	import cpu_bus_pkg::*;
();

	localparam int          CLK_PERIOD = 40;
	localparam int          RST_CYCLES = 8;
	localparam int          MEM_WORDS  = 1024;
	localparam logic [31:0] MEM_SEED   = 32'he1d2_17b1;
	// port we sel addr wdata interlock rdata
	localparam int          VEC_COLS   = 7;
	localparam int          MAX_LINES  = 64;
	localparam int          ILK_CYCLES = 3;
	localparam int          ACC_LIMIT  = 20;

	logic                  clk = 1'b0;
	logic                  rst_n;
	cpu_req_t              ibus_req;
	cpu_req_t              dbus_req;
	logic                  ibus_ilk;
	logic                  dbus_ilk;
	logic                  ibus_busy;
	logic                  dbus_busy;
	logic [CPU_DATA_W-1:0] ibus_rdata;
	logic [CPU_DATA_W-1:0] dbus_rdata;
	wb_req_t               mem_req;
	wb_rsp_t               mem_rsp;

	logic [31:0]           vec [0:MAX_LINES*VEC_COLS-1];
	int                    num_lines = 0;
	logic                  vec_loaded = 1'b0;
	int                    errors = 0;
	// last expected read per port, 1 = data
	logic [31:0]           last_rd [0:1];

	always #(CLK_PERIOD / 2) clk = ~clk;

	cpu_bus_top cpu_bus_top_inst (
		.clk              (clk),
		.rst_n_i          (rst_n),
		.ibus_req_i       (ibus_req),
		.ibus_interlock_i (ibus_ilk),
		.ibus_busy_o      (ibus_busy),
		.ibus_rdata_o     (ibus_rdata),
		.dbus_req_i       (dbus_req),
		.dbus_interlock_i (dbus_ilk),
		.dbus_busy_o      (dbus_busy),
		.dbus_rdata_o     (dbus_rdata),
		.mem_req_o        (mem_req),
		.mem_rsp_i        (mem_rsp)
	);

	cpu_bus_mem_model #(.MEM_WORDS(MEM_WORDS), .SEED(MEM_SEED)) u_mem (
		.clk     (clk),
		.rst_n_i (rst_n),
		.req_i   (mem_req),
		.rsp_o   (mem_rsp)
	);

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------

	task automatic check_value(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		if (act_v !== exp_v) begin
			$display("ERROR t=%0t %s expected %h actual %h", $time, name, exp_v, act_v);
			errors++;
		end
	endtask

	task automatic note_failure(input string what);
		$display("t=%0t %s", $time, what);
		errors++;
	endtask

	function automatic logic port_busy(input bit is_data);
		return is_data ? dbus_busy : ibus_busy;
	endfunction

	function automatic logic [31:0] port_rdata(input bit is_data);
		return is_data ? dbus_rdata : ibus_rdata;
	endfunction

	task automatic drive_port(input bit is_data, input cpu_req_t r);
		if (is_data) dbus_req = r;
		else ibus_req = r;
	endtask

	task automatic set_interlock(input bit is_data, input logic v);
		if (is_data) dbus_ilk = v;
		else ibus_ilk = v;
	endtask

	// one vector line on one port, starts on a falling edge
	task automatic run_access(input int ln, input bit is_data);
		int       base;
		int       cycles;
		string    pname;
		cpu_req_t r;
		base    = ln * VEC_COLS;
		pname   = is_data ? "dbus" : "ibus";
		r.en    = 1'b1;
		r.we    = vec[base + 1][0];
		r.sel   = vec[base + 2][WB_SEL_W-1:0];
		r.addr  = vec[base + 3];
		r.wdata = vec[base + 4];
		drive_port(is_data, r);
		// stalled core, request must not reach memory
		if (vec[base + 5][0]) begin
			set_interlock(is_data, 1'b1);
			repeat (ILK_CYCLES) begin
				@(negedge clk);
				check_value({pname, "_busy_o"}, 32'd0, 32'(port_busy(is_data)));
				check_value("mem stb", 32'd0, 32'(mem_req.stb));
				check_value({pname, "_rdata_o"}, last_rd[is_data], port_rdata(is_data));
			end
			set_interlock(is_data, 1'b0);
		end
		@(negedge clk);
		if (!port_busy(is_data)) note_failure({pname, " request was not accepted"});
		cycles = 0;
		while (port_busy(is_data) && cycles < ACC_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (port_busy(is_data)) note_failure({pname, " access never completed"});
		// en drops before the next capture edge
		r.en = 1'b0;
		drive_port(is_data, r);
		check_value({pname, "_rdata_o"}, vec[base + 6], port_rdata(is_data));
		last_rd[is_data] = vec[base + 6];
	endtask

	// ------------------------------------------------------------------------
	// memory port stays put while a strobe waits for ack
	// ------------------------------------------------------------------------

	logic    hold_q = 1'b0;
	wb_req_t prev_req;

	always @(negedge clk) begin
		if (rst_n && hold_q && mem_req.stb) begin
			check_value("mem adr", 32'(prev_req.adr), 32'(mem_req.adr));
			check_value("mem dat", prev_req.dat, mem_req.dat);
			check_value("mem sel", 32'(prev_req.sel), 32'(mem_req.sel));
			check_value("mem we", 32'(prev_req.we), 32'(mem_req.we));
		end
		hold_q   = rst_n & mem_req.stb & ~mem_rsp.ack;
		prev_req = mem_req;
	end

	// ------------------------------------------------------------------------
	// sequence
	// ------------------------------------------------------------------------

	initial begin
		int line;
		int base_cnt;
		rst_n      = 1'b0;
		ibus_req   = '0;
		dbus_req   = '0;
		ibus_ilk   = 1'b0;
		dbus_ilk   = 1'b0;
		last_rd[0] = '0;
		last_rd[1] = '0;
		for (int k = 0; k < MAX_LINES * VEC_COLS; k++) vec[k] = '1;
		$readmemh("bench/cpu_bus_vectors.txt", vec);
		while (num_lines < MAX_LINES && vec[num_lines * VEC_COLS] != '1) num_lines++;
		vec_loaded = 1'b1;
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		// idle state out of reset
		check_value("ibus_busy_o", 32'd0, 32'(ibus_busy));
		check_value("dbus_busy_o", 32'd0, 32'(dbus_busy));
		check_value("mem cyc", 32'd0, 32'(mem_req.cyc));
		check_value("mem stb", 32'd0, 32'(mem_req.stb));
		check_value("ibus_rdata_o", 32'd0, ibus_rdata);
		check_value("dbus_rdata_o", 32'd0, dbus_rdata);
		line = 0;
		while (line < num_lines) begin
			if (vec[line * VEC_COLS] != 32'd3) begin
				run_access(line, vec[line * VEC_COLS] == 32'd2);
				line++;
			end else if (line + 1 >= num_lines || vec[(line + 1) * VEC_COLS] != 32'd1) begin
				note_failure("paired data line has no instruction line after it");
				line++;
			end else begin
				// both ports in one cycle, data must reach memory first
				base_cnt = u_mem.log_cnt;
				fork
					run_access(line, 1'b1);
					run_access(line + 1, 1'b0);
				join
				check_value("mem log count", 32'(base_cnt + 2), 32'(u_mem.log_cnt));
				check_value("first adr", 32'(vec[line * VEC_COLS + 3][31:2]),
					32'(u_mem.log_adr[base_cnt]));
				check_value("second adr", 32'(vec[(line + 1) * VEC_COLS + 3][31:2]),
					32'(u_mem.log_adr[base_cnt + 1]));
				line += 2;
			end
		end
		repeat (2) @(negedge clk);
		$display("summary: %0d errors over %0d vector lines", errors, num_lines);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

	// watchdog, ten periods per access plus reset
	initial begin
		wait (vec_loaded);
		#(CLK_PERIOD * (num_lines * 10 + 20));
		$display("watchdog expired, the accesses did not finish in time");
		$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== bench/cpu_bus_mem_model.sv ====
// wishbone memory model
// classic slave with random wait states and a log of accepted addresses

module cpu_bus_mem_model
	import cpu_bus_pkg::*;
#(
	parameter int          MEM_WORDS = 1024,
	parameter logic [31:0] SEED      = 32'h1,
	parameter int          LOG_DEPTH = 128
) (
	input  logic    clk,
	input  logic    rst_n_i,
	input  wb_req_t req_i,
	output wb_rsp_t rsp_o
);

	logic [CPU_DATA_W-1:0] mem [0:MEM_WORDS-1];

	// word addresses in the order their strobes were acked
	logic [WB_ADR_W-1:0]   log_adr [0:LOG_DEPTH-1];
	int                    log_cnt;

	integer                seed;
	logic                  waiting;
	int                    wait_cnt;

	always @(posedge clk) begin : serve
		int                    wait_n;
		int                    idx;
		logic                  fire;
		logic [CPU_DATA_W-1:0] merged;
		fire = 1'b0;
		idx  = int'(req_i.adr) % MEM_WORDS;
		if (!rst_n_i) begin
			seed     = SEED;
			rsp_o    <= '0;
			waiting  <= 1'b0;
			wait_cnt <= 0;
			log_cnt  <= 0;
			// fill pattern, word address xor a fixed tag
			for (int i = 0; i < MEM_WORDS; i++) begin
				mem[i] <= 32'(i) ^ 32'h5a5a_0000;
			end
		end else begin
			rsp_o.ack <= 1'b0;
			// a strobe still held in the ack cycle is not a new access
			if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
				if (!waiting) begin
					// 0 to 3 wait states per access
					wait_n = $random(seed) & 3;
					if (wait_n == 0) begin
						fire = 1'b1;
					end else begin
						waiting  <= 1'b1;
						wait_cnt <= wait_n - 1;
					end
				end else if (wait_cnt == 0) begin
					waiting <= 1'b0;
					fire    = 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 1;
				end
			end
			if (fire) begin
				merged = mem[idx];
				// byte lanes picked by sel
				for (int b = 0; b < WB_SEL_W; b++) begin
					if (req_i.sel[b]) begin
						merged[8*b +: 8] = req_i.dat[8*b +: 8];
					end
				end
				if (req_i.we) begin
					mem[idx] <= merged;
				end
				rsp_o.dat <= mem[idx];
				rsp_o.ack <= 1'b1;
				if (log_cnt < LOG_DEPTH) begin
					log_adr[log_cnt] <= req_i.adr;
				end
				log_cnt <= log_cnt + 1;
			end
		end
	end

endmodule

// ==== hdl/cpu_bus_top.sv ====
// cpu memory access top
// instruction and data bus bridges merged onto a single wishbone memory port

module cpu_bus_top
	import cpu_bus_pkg::*;
(
	// system
	input  logic                  clk,
	input  logic                  rst_n_i,

	// instruction bus from the core
	input  cpu_req_t              ibus_req_i,
	input  logic                  ibus_interlock_i,
	output logic                  ibus_busy_o,
	output logic [CPU_DATA_W-1:0] ibus_rdata_o,

	// data bus from the core
	input  cpu_req_t              dbus_req_i,
	input  logic                  dbus_interlock_i,
	output logic                  dbus_busy_o,
	output logic [CPU_DATA_W-1:0] dbus_rdata_o,

	// wishbone memory port
	output wb_req_t               mem_req_o,
	input  wb_rsp_t               mem_rsp_i
);

	// ------------------------------------------------------------------------
	// bridges
	// ------------------------------------------------------------------------

	// per-side wishbone links into the arbiter
	wb_req_t inst_wb_req;
	wb_rsp_t inst_wb_rsp;
	wb_req_t data_wb_req;
	wb_rsp_t data_wb_rsp;

	// instruction fetch side
	cpu_bus_bridge u_bridge_inst (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_i       (ibus_req_i),
		.interlock_i (ibus_interlock_i),
		.busy_o      (ibus_busy_o),
		.rdata_o     (ibus_rdata_o),
		.wb_req_o    (inst_wb_req),
		.wb_rsp_i    (inst_wb_rsp)
	);

	// load/store side
	cpu_bus_bridge u_bridge_data (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.req_i       (dbus_req_i),
		.interlock_i (dbus_interlock_i),
		.busy_o      (dbus_busy_o),
		.rdata_o     (dbus_rdata_o),
		.wb_req_o    (data_wb_req),
		.wb_rsp_i    (data_wb_rsp)
	);

	// ------------------------------------------------------------------------
	// arbiter
	// ------------------------------------------------------------------------

	// its memory side is the top's memory port
	cpu_bus_arbiter u_arbiter (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.inst_req_i (inst_wb_req),
		.inst_rsp_o (inst_wb_rsp),
		.data_req_i (data_wb_req),
		.data_rsp_o (data_wb_rsp),
		.mem_req_o  (mem_req_o),
		.mem_rsp_i  (mem_rsp_i)
	);

endmodule

// ==== hdl/cpu_bus_arbiter.sv ====
// wishbone arbiter
// merges the instruction and data masters onto one memory master,
// data side first, grant held until the memory ack

module cpu_bus_arbiter
	import cpu_bus_pkg::*;
(
	// system
	input  logic    clk,
	input  logic    rst_n_i,

	// instruction master
	input  wb_req_t inst_req_i,
	output wb_rsp_t inst_rsp_o,

	// data master
	input  wb_req_t data_req_i,
	output wb_rsp_t data_rsp_o,

	// memory side
	output wb_req_t mem_req_o,
	input  wb_rsp_t mem_rsp_i
);

	// ------------------------------------------------------------------------
	// grant
	// ------------------------------------------------------------------------

	// memory cycle still waiting for ack
	logic busy_q;

	// registered owner while busy, 1 = data master
	logic grant_data_q;

	// owner for the current cycle
	logic grant_data;

	// idle means pick straight from the strobes, no extra cycle
	// data wins a tie, instruction only when data is quiet
	always_comb begin
		if (busy_q) begin
			grant_data = grant_data_q;
		end else if (data_req_i.stb) begin
			grant_data = 1'b1;
		end else begin
			grant_data = 1'b0;
		end
	end

	// hold the owner across wait states
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			busy_q       <= 1'b0;
			grant_data_q <= 1'b0;
		end else begin
			// stays set while the strobe waits, clears on the ack edge
			busy_q <= mem_req_o.stb & ~mem_rsp_i.ack;

			// owner latched at the start of a cycle only
			if (!busy_q) begin
				grant_data_q <= grant_data;
			end
		end
	end

	// ------------------------------------------------------------------------
	// request mux
	// ------------------------------------------------------------------------

	// whole struct follows the owner, loser is simply not seen
	always_comb begin
		if (grant_data) begin
			mem_req_o = data_req_i;
		end else begin
			mem_req_o = inst_req_i;
		end
	end

	// ------------------------------------------------------------------------
	// response steering
	// ------------------------------------------------------------------------

	// ack and data only to the owner, the other side keeps waiting
	always_comb begin
		inst_rsp_o = '0;
		data_rsp_o = '0;
		if (grant_data) begin
			data_rsp_o = mem_rsp_i;
		end else begin
			inst_rsp_o = mem_rsp_i;
		end
	end

endmodule

// ==== hdl/cpu_bus_bridge.sv ====
// core bus to wishbone bridge
// turns a core-side en/busy request into one wishbone classic master

module cpu_bus_bridge
	import cpu_bus_pkg::*;
(
	// system
	input  logic                  clk,
	input  logic                  rst_n_i,

	// core side
	input  cpu_req_t              req_i,
	input  logic                  interlock_i,
	output logic                  busy_o,
	output logic [CPU_DATA_W-1:0] rdata_o,

	// wishbone master
	output wb_req_t               wb_req_o,
	input  wb_rsp_t               wb_rsp_i
);

	// ------------------------------------------------------------------------
	// handshake
	// ------------------------------------------------------------------------

	// cycle in flight, drives cyc, stb and busy
	logic                  cyc_q;

	// latched request payload
	logic [WB_ADR_W-1:0]   adr_q;
	logic [CPU_DATA_W-1:0] dat_q;
	logic                  we_q;
	logic [WB_SEL_W-1:0]   sel_q;

	logic                  accept;
	logic                  done;

	// new request only when idle and pipeline not stalled elsewhere
	assign accept = req_i.en & ~cyc_q & ~interlock_i;

	// slave finished the current cycle
	assign done = cyc_q & wb_rsp_i.ack;

	// cyc/stb from the cycle after capture up to and including ack
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			cyc_q <= 1'b0;
		end else if (accept) begin
			cyc_q <= 1'b1;
		end else if (done) begin
			// drop on the ack edge, low in the next cycle
			cyc_q <= 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// request payload
	// ------------------------------------------------------------------------

	// held constant for the whole cycle, only loaded on accept
	always_ff @(posedge clk) begin
		if (accept) begin
			// byte address to word address
			adr_q <= req_i.addr[CPU_ADDR_W-1:ADR_LSB];
			dat_q <= req_i.wdata;
			we_q  <= req_i.we;
			sel_q <= req_i.sel;
		end
	end

	// ------------------------------------------------------------------------
	// read data
	// ------------------------------------------------------------------------

	// read data kept for the core until the next read completes
	// writes and interlock leave it alone
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rdata_o <= '0;
		end else if (done && !we_q) begin
			rdata_o <= wb_rsp_i.dat;
		end
	end

	// ------------------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------------------

	// core holds its request while this is high
	assign busy_o = cyc_q;

	// classic single access, cyc and stb move together
	assign wb_req_o.adr = adr_q;
	assign wb_req_o.dat = dat_q;
	assign wb_req_o.we  = we_q;
	assign wb_req_o.sel = sel_q;
	assign wb_req_o.cyc = cyc_q;
	assign wb_req_o.stb = cyc_q;

endmodule

// ==== hdl/cpu_bus_pkg.sv ====
// cpu bus package
// widths and struct types shared by the core-side bus bridges,
// the wishbone arbiter and the memory port

package cpu_bus_pkg;

	// ------------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------------

	// core-side byte address and data
	localparam int CPU_ADDR_W = 32;
	localparam int CPU_DATA_W = 32;

	// wishbone word address, core address without the byte offset
	localparam int WB_ADR_W   = 30;

	// byte lanes per word
	localparam int WB_SEL_W   = 4;

	// low address bits dropped on the way to wishbone
	localparam int ADR_LSB    = CPU_ADDR_W - WB_ADR_W;

	// ------------------------------------------------------------------------
	// bus structs
	// ------------------------------------------------------------------------

	// one core-side request, held steady by the core while busy
	typedef struct packed {
		logic                  en;
		logic                  we;
		logic [WB_SEL_W-1:0]   sel;
		logic [CPU_ADDR_W-1:0] addr;
		logic [CPU_DATA_W-1:0] wdata;
	} cpu_req_t;

	// wishbone classic master outputs
	typedef struct packed {
		logic [WB_ADR_W-1:0]   adr;
		logic [CPU_DATA_W-1:0] dat;
		logic                  we;
		logic [WB_SEL_W-1:0]   sel;
		logic                  cyc;
		logic                  stb;
	} wb_req_t;

	// wishbone slave outputs, ack is a single cycle pulse
	typedef struct packed {
		logic [CPU_DATA_W-1:0] dat;
		logic                  ack;
	} wb_rsp_t;

endpackage
